//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_l1_cache
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
logic/cache_geom_pkg.sv
logic/cache_ops_pkg.sv
logic/lane_align.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/l1_cache.sv
testbench/l1_cache_asserts.sv
testbench/tb_l1_cache.sv

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
	parameter int INDEX_BITS = 4,
	parameter int WORDS_LOG2 = 4,
	localparam int TAG_BITS = cache_geom_pkg::ADDR_BITS - INDEX_BITS - WORDS_LOG2 - 2
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ren,
	input  logic                       wen,
	input  cache_ops_pkg::core_req_t   req,
	input  logic                       hit,
	input  logic                       hit_way,
	input  logic                       victim_way,
	input  logic                       victim_dirty,
	input  logic [TAG_BITS-1:0]        victim_tag,
	input  cache_geom_pkg::word_t      rd_word,
	input  cache_geom_pkg::word_t      load_data,
	input  cache_geom_pkg::lane_mask_t store_we,
	input  cache_geom_pkg::word_t      store_data,
	input  cache_geom_pkg::word_t      mem_dout,
	output logic                       rdy,
	output cache_geom_pkg::word_t      dout,
	output logic                       mem_ren,
	output logic                       mem_wen,
	output cache_geom_pkg::addr_t      mem_addr,
	output cache_geom_pkg::word_t      mem_din,
	output cache_ops_pkg::core_req_t   cur_req,
	output logic                       cur_wen,
	output logic [INDEX_BITS-1:0]      lookup_index,
	output logic [TAG_BITS-1:0]        lookup_tag,
	output logic                       tag_touch,
	output logic                       tag_fill,
	output logic                       tag_dirty,
	output logic                       ds_way,
	output logic [INDEX_BITS-1:0]      ds_set,
	output logic [WORDS_LOG2-1:0]      ds_word,
	output logic                       ds_read,
	output cache_geom_pkg::lane_mask_t ds_lane_we,
	output cache_geom_pkg::word_t      ds_lane_data
);
	import cache_geom_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		ACCESS,
		WRITEBACK,
		FILL
	} state_e;

	state_e state;
	logic accept;
	// block word counter, top bit set means the last word is in flight
	logic [WORDS_LOG2:0] cnt;
	logic [WORDS_LOG2:0] cnt_prev;
	logic cnt_done;
	logic [WORDS_LOG2-1:0] req_word;

	assign accept = (state == IDLE) && rdy && (ren || wen);
	assign lookup_index = cur_req.addr[WORDS_LOG2+2 +: INDEX_BITS];
	assign lookup_tag = cur_req.addr[WORDS_LOG2+2+INDEX_BITS +: TAG_BITS];
	assign req_word = cur_req.addr[2 +: WORDS_LOG2];
	assign cnt_prev = cnt - 1'b1;
	assign cnt_done = cnt[WORDS_LOG2];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			rdy <= 1'b0;
			dout <= '0;
			cur_wen <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						cur_wen <= wen;
						rdy <= 1'b0;
						state <= LOOKUP;
					end else begin
						rdy <= 1'b1;
					end
				end
				LOOKUP: begin
					cnt <= '0;
					if (hit) begin
						state <= ACCESS;
					end else if (victim_dirty) begin
						state <= WRITEBACK;
					end else begin
						state <= FILL;
					end
				end
				ACCESS: begin
					if (!cur_wen) begin
						dout <= load_data;
					end
					rdy <= 1'b1;
					state <= IDLE;
				end
				WRITEBACK: begin
					cnt <= cnt + 1'b1;
					if (cnt_done) begin
						cnt <= '0;
						state <= FILL;
					end
				end
				FILL: begin
					cnt <= cnt + 1'b1;
					// replay through lookup, which now hits
					if (cnt_done) begin
						state <= LOOKUP;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cur_req <= req;
		end
	end

	// victim way and tag hold still until the fill strobe
	always_comb begin
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		mem_addr = '0;
		mem_din = '0;
		tag_touch = 1'b0;
		tag_fill = 1'b0;
		tag_dirty = 1'b0;
		ds_way = hit_way;
		ds_set = lookup_index;
		ds_word = req_word;
		ds_read = 1'b0;
		ds_lane_we = '0;
		ds_lane_data = store_data;
		case (state)
			LOOKUP: begin
				tag_touch = hit;
				tag_dirty = hit && cur_wen;
				ds_read = hit && !cur_wen;
				ds_lane_we = hit ? store_we : '0;
			end
			WRITEBACK: begin
				// read word n while word n-1 goes out to memory
				ds_way = victim_way;
				ds_word = cnt[WORDS_LOG2-1:0];
				ds_read = !cnt_done;
				mem_wen = (cnt != '0);
				mem_addr = {victim_tag, lookup_index, cnt_prev[WORDS_LOG2-1:0], 2'b00};
				mem_din = rd_word;
			end
			FILL: begin
				// request word n while word n-1 comes back
				ds_way = victim_way;
				ds_word = cnt_prev[WORDS_LOG2-1:0];
				ds_lane_we = {LANES{cnt != '0}};
				ds_lane_data = mem_dout;
				mem_ren = !cnt_done;
				mem_addr = {lookup_tag, lookup_index, cnt[WORDS_LOG2-1:0], 2'b00};
				tag_fill = cnt_done;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

	// data path widths
	localparam int WORD_BITS = 32;
	localparam int ADDR_BITS = 32;

	// byte lanes per word
	localparam int LANES = WORD_BITS / 8;

	// one data word
	typedef logic [WORD_BITS-1:0] word_t;

	// byte address as seen by the core and by memory
	typedef logic [ADDR_BITS-1:0] addr_t;

	// one write enable per byte lane
	typedef logic [LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

//--- logic/cache_ops_pkg.sv
`default_nettype none

package cache_ops_pkg;

	// load kinds, signed and unsigned narrow loads
	typedef enum logic [2:0] {
		LOAD_BS = 3'd0,
		LOAD_HS = 3'd1,
		LOAD_W  = 3'd2,
		LOAD_BU = 3'd3,
		LOAD_HU = 3'd4
	} load_op_e;

	// store kinds
	typedef enum logic [1:0] {
		STORE_B = 2'd0,
		STORE_H = 2'd1,
		STORE_W = 2'd2
	} store_op_e;

	// one core request, 69 bits
	typedef struct packed {
		cache_geom_pkg::addr_t addr;
		cache_geom_pkg::word_t data;
		load_op_e load_op;
		store_op_e store_op;
	} core_req_t;

endpackage

`default_nettype wire

//--- logic/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store #(
	parameter int INDEX_BITS = 4,
	parameter int WORDS_LOG2 = 4
) (
	input  logic                       clk,
	input  logic                       ds_way,
	input  logic [INDEX_BITS-1:0]      ds_set,
	input  logic [WORDS_LOG2-1:0]      ds_word,
	input  logic                       ds_read,
	input  cache_geom_pkg::lane_mask_t ds_lane_we,
	input  cache_geom_pkg::word_t      ds_lane_data,
	output cache_geom_pkg::word_t      rd_word
);
	import cache_geom_pkg::*;

	localparam int ROW_BITS = 1 + INDEX_BITS + WORDS_LOG2;

	logic [ROW_BITS-1:0] row;

	// way is the top row bit, word the bottom
	assign row = {ds_way, ds_set, ds_word};

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		logic [7:0] cells [1 << ROW_BITS];
		logic [7:0] rd_byte;

		always_ff @(posedge clk) begin
			if (ds_lane_we[l]) begin
				cells[row] <= ds_lane_data[8*l +: 8];
			end
			if (ds_read) begin
				rd_byte <= cells[row];
			end
		end

		assign rd_word[8*l +: 8] = rd_byte;
	end

endmodule

`default_nettype wire

//--- logic/l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
	parameter int INDEX_BITS = 4,
	parameter int WORDS_LOG2 = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ren,
	input  logic                     wen,
	input  cache_ops_pkg::core_req_t req,
	output logic                     rdy,
	output cache_geom_pkg::word_t    dout,
	output logic                     mem_ren,
	output logic                     mem_wen,
	output cache_geom_pkg::addr_t    mem_addr,
	output cache_geom_pkg::word_t    mem_din,
	input  cache_geom_pkg::word_t    mem_dout
);
	import cache_geom_pkg::*;
	import cache_ops_pkg::*;

	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - WORDS_LOG2 - 2;

	// registered request and lane alignment
	core_req_t cur_req;
	logic cur_wen;
	lane_mask_t store_we;
	word_t store_data;
	word_t load_data;

	// tag lookup
	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0] lookup_tag;
	logic tag_touch;
	logic tag_fill;
	logic tag_dirty;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;

	// data store port
	logic ds_way;
	logic [INDEX_BITS-1:0] ds_set;
	logic [WORDS_LOG2-1:0] ds_word;
	logic ds_read;
	lane_mask_t ds_lane_we;
	word_t ds_lane_data;
	word_t rd_word;

	cache_ctrl #(
		.INDEX_BITS(INDEX_BITS),
		.WORDS_LOG2(WORDS_LOG2)
	) i_cache_ctrl (.*);

	tag_store #(
		.INDEX_BITS(INDEX_BITS),
		.WORDS_LOG2(WORDS_LOG2)
	) i_tag_store (.*);

	data_store #(
		.INDEX_BITS(INDEX_BITS),
		.WORDS_LOG2(WORDS_LOG2)
	) i_data_store (.*);

	lane_align i_lane_align (.*);

endmodule

`default_nettype wire

//--- logic/lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align (
	input  cache_ops_pkg::core_req_t   cur_req,
	input  logic                       cur_wen,
	input  cache_geom_pkg::word_t      rd_word,
	output cache_geom_pkg::lane_mask_t store_we,
	output cache_geom_pkg::word_t      store_data,
	output cache_geom_pkg::word_t      load_data
);
	import cache_geom_pkg::*;
	import cache_ops_pkg::*;

	logic [1:0] byte_sel;
	lane_mask_t lane_mask;
	word_t shifted;

	assign byte_sel = cur_req.addr[1:0];

	// narrow stores are copied into every lane, the mask picks the target
	always_comb begin
		case (cur_req.store_op)
			STORE_B: begin
				store_data = {LANES{cur_req.data[7:0]}};
				lane_mask = 4'b0001 << byte_sel;
			end
			STORE_H: begin
				store_data = {2{cur_req.data[15:0]}};
				lane_mask = 4'b0011 << {byte_sel[1], 1'b0};
			end
			default: begin
				store_data = cur_req.data;
				lane_mask = '1;
			end
		endcase
		store_we = cur_wen ? lane_mask : '0;
	end

	// addressed byte or halfword moved down to bit 0
	assign shifted = rd_word >> {byte_sel, 3'b000};

	always_comb begin
		case (cur_req.load_op)
			LOAD_BS: load_data = {{24{shifted[7]}}, shifted[7:0]};
			LOAD_HS: load_data = {{16{shifted[15]}}, shifted[15:0]};
			LOAD_BU: load_data = {24'h0, shifted[7:0]};
			LOAD_HU: load_data = {16'h0, shifted[15:0]};
			default: load_data = rd_word;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
	parameter int INDEX_BITS = 4,
	parameter int WORDS_LOG2 = 4,
	localparam int TAG_BITS = cache_geom_pkg::ADDR_BITS - INDEX_BITS - WORDS_LOG2 - 2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [INDEX_BITS-1:0] lookup_index,
	input  logic [TAG_BITS-1:0]   lookup_tag,
	input  logic                  tag_touch,
	input  logic                  tag_fill,
	input  logic                  tag_dirty,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output logic [TAG_BITS-1:0]   victim_tag
);
	localparam int SETS = 1 << INDEX_BITS;

	logic [TAG_BITS-1:0] tags [2][SETS];
	logic [1:0] valid [SETS];
	logic [1:0] dirty [SETS];
	// lru[s] names the way used least recently in set s
	logic [SETS-1:0] lru;
	logic [1:0] way_hit;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid[lookup_index][w] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	// empty way first, otherwise the lru way
	always_comb begin
		if (!valid[lookup_index][0]) begin
			victim_way = 1'b0;
		end else if (!valid[lookup_index][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru[lookup_index];
		end
	end

	assign victim_dirty = dirty[lookup_index][victim_way];
	assign victim_tag = tags[victim_way][lookup_index];

	always_ff @(posedge clk) begin
		if (tag_fill) begin
			tags[victim_way][lookup_index] <= lookup_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
			end
			lru <= '0;
		end else begin
			if (tag_touch) begin
				lru[lookup_index] <= ~hit_way;
			end
			if (tag_dirty) begin
				dirty[lookup_index][hit_way] <= 1'b1;
			end
			// new line comes in clean
			if (tag_fill) begin
				valid[lookup_index][victim_way] <= 1'b1;
				dirty[lookup_index][victim_way] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/cache_stimulus.txt
# kind opcode address store_data expected_load, all numbers in hex
# kind L takes load_op_e codes (0 BS 1 HS 2 W 3 BU 4 HU), kind S takes store_op_e codes (0 B 1 H 2 W)
L 2 00123458 00000000 FFFB8D16
L 0 00000200 00000000 FFFFFF80
L 3 00000642 00000000 000000FF
L 1 00020AC0 00000000 FFFF82B0
L 4 00123CC6 00000000 0000FFFB
L 0 00123CC5 00000000 FFFFFF8F
S 0 00000201 000000A5 00000000
S 1 00000202 00001234 00000000
L 2 00000200 00000000 1234A580
L 0 00000201 00000000 FFFFFFA5
L 4 00000202 00000000 00001234
S 0 00000347 0000005A 00000000
L 2 00000344 00000000 5AFF00D1
L 2 00000348 00000000 FFFF00D2
L 2 00000140 00000000 FFFF0050
S 2 00000548 DEADBEEF 00000000
L 2 00000144 00000000 FFFF0051
L 2 00000944 00000000 FFFF0251
L 2 00000140 00000000 FFFF0050
L 2 00000548 00000000 DEADBEEF
L 2 0000054C 00000000 FFFF0153
L 3 00000203 00000000 00000012
S 2 00000200 87654321 00000000
L 1 00000202 00000000 FFFF8765

//--- testbench/l1_cache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_asserts (
	input logic                     clk,
	input logic                     rst,
	input logic                     ren,
	input logic                     wen,
	input cache_ops_pkg::core_req_t req,
	input logic                     rdy,
	input logic                     hit,
	input logic                     mem_ren,
	input logic                     mem_wen
);
	import cache_ops_pkg::*;

	logic accept;
	// a request was taken on the previous edge
	logic accept_d;
	logic misaligned;

	assign accept = rdy && (ren || wen);

	always_ff @(posedge clk) begin
		if (rst) begin
			accept_d <= 1'b0;
		end else begin
			accept_d <= accept;
		end
	end

	always_comb begin
		misaligned = 1'b0;
		if (ren && (req.load_op == LOAD_HS || req.load_op == LOAD_HU)) begin
			misaligned = req.addr[0];
		end
		if (ren && req.load_op == LOAD_W) begin
			misaligned = |req.addr[1:0];
		end
		if (wen && req.store_op == STORE_H) begin
			misaligned = req.addr[0];
		end
		if (wen && req.store_op == STORE_W) begin
			misaligned = |req.addr[1:0];
		end
	end

	mem_strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_ren && mem_wen))
		else $error("mem_ren and mem_wen high together");

	rdy_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !rdy)
		else $error("rdy high in the first cycle after reset");

	aligned_request: assert property (@(posedge clk) disable iff (rst)
		accept |-> !misaligned)
		else $error("misaligned request accepted");

	// lookup cycle hit, then one access cycle
	hit_latency: assert property (@(posedge clk) disable iff (rst)
		(accept_d && hit) |=> !rdy ##1 rdy)
		else $error("hit did not return rdy after two cycles");

endmodule

`default_nettype wire

//--- testbench/tb_l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;
	import cache_geom_pkg::*;
	import cache_ops_pkg::*;

	localparam int INDEX_BITS = 4;
	localparam int WORDS_LOG2 = 4;
	localparam int BLOCK_WORDS = 1 << WORDS_LOG2;
	localparam int SETS = 1 << INDEX_BITS;
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - WORDS_LOG2 - 2;
	localparam int CYCLES_PER_LINE = 400;

	// one request from the stimulus file
	typedef struct packed {
		logic is_store;
		logic [2:0] opcode;
		word_t addr;
		word_t data;
		word_t expected;
	} stim_t;

	logic clk = 1'b0;
	logic rst;
	logic ren;
	logic wen;
	core_req_t req;
	logic rdy;
	word_t dout;
	logic mem_ren;
	logic mem_wen;
	addr_t mem_addr;
	word_t mem_din;
	word_t mem_dout = '0;
	word_t mem_word_addr;

	stim_t stim [$];
	// only words written back by the cache live here
	word_t mem_words [word_t];
	word_t last_load = '0;
	int errors = 0;
	int cycles = 0;
	int limit = CYCLES_PER_LINE;

	// expected tag state, two ways per set
	logic [TAG_BITS-1:0] model_tag [2][SETS];
	logic [1:0] model_valid [SETS];
	logic [1:0] model_dirty [SETS];
	logic [SETS-1:0] model_lru;

	l1_cache #(
		.INDEX_BITS(INDEX_BITS),
		.WORDS_LOG2(WORDS_LOG2)
	) i_l1_cache (
		.clk(clk),
		.rst(rst),
		.ren(ren),
		.wen(wen),
		.req(req),
		.rdy(rdy),
		.dout(dout),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_din(mem_din),
		.mem_dout(mem_dout)
	);

	bind l1_cache l1_cache_asserts i_l1_cache_asserts (
		.clk(clk),
		.rst(rst),
		.ren(ren),
		.wen(wen),
		.req(req),
		.rdy(rdy),
		.hit(hit),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen)
	);

	always #50 clk = ~clk;

	// word address w holds w with its upper half inverted
	function automatic word_t initial_word(input word_t w);
		return {~w[31:16], w[15:0]};
	endfunction

	assign mem_word_addr = {2'b00, mem_addr[31:2]};

	// read data comes back one cycle after mem_ren
	always @(posedge clk) begin
		if (mem_wen) begin
			mem_words[mem_word_addr] = mem_din;
		end
		if (mem_ren) begin
			if (mem_words.exists(mem_word_addr)) begin
				mem_dout <= mem_words[mem_word_addr];
			end else begin
				mem_dout <= initial_word(mem_word_addr);
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the cache stopped answering requests", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// expected hit and writeback of one request, the model then takes the access
	task automatic predict_lookup(input stim_t s, output logic expect_hit,
		output logic expect_wb);
		int idx;
		logic [TAG_BITS-1:0] tag;
		logic way;
		idx = int'((s.addr >> (WORDS_LOG2 + 2)) % SETS);
		tag = s.addr[ADDR_BITS-1 -: TAG_BITS];
		expect_hit = 1'b0;
		expect_wb = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (model_valid[idx][w] && model_tag[w][idx] == tag) begin
				expect_hit = 1'b1;
				way = w[0];
			end
		end
		if (!expect_hit) begin
			// empty way first, then the least recently used one
			if (!model_valid[idx][0]) begin
				way = 1'b0;
			end else if (!model_valid[idx][1]) begin
				way = 1'b1;
			end else begin
				way = model_lru[idx];
			end
			expect_wb = model_dirty[idx][way];
			model_tag[way][idx] = tag;
			model_valid[idx][way] = 1'b1;
			model_dirty[idx][way] = 1'b0;
		end
		if (s.is_store) begin
			model_dirty[idx][way] = 1'b1;
		end
		model_lru[idx] = ~way;
	endtask

	task automatic load_stimulus();
		int fd;
		int got;
		string line;
		stim_t s;
		word_t op;
		word_t addr;
		word_t data;
		word_t expected;
		fd = $fopen("testbench/cache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file testbench/cache_stimulus.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			got = $fgets(line, fd);
			// request lines start with L or S, anything else is skipped
			if (got > 2 && (line.getc(0) == "L" || line.getc(0) == "S")) begin
				got = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h",
					op, addr, data, expected);
				if (got != 4) begin
					$display("malformed stimulus line: %s", line);
					errors++;
				end else begin
					s.is_store = (line.getc(0) == "S");
					s.opcode = op[2:0];
					s.addr = addr;
					s.data = data;
					s.expected = expected;
					stim.push_back(s);
				end
			end
		end
		$fclose(fd);
		if (stim.size() == 0) begin
			$display("the stimulus file holds no requests");
			errors++;
		end
	endtask

	task automatic run_request(input stim_t s);
		core_req_t r;
		int n;
		int reads;
		int writes;
		logic expect_hit;
		logic expect_wb;
		predict_lookup(s, expect_hit, expect_wb);
		r.addr = s.addr;
		r.data = s.data;
		r.load_op = s.is_store ? LOAD_W : load_op_e'(s.opcode);
		r.store_op = s.is_store ? store_op_e'(s.opcode[1:0]) : STORE_W;
		while (!rdy) begin
			@(posedge clk);
		end
		req <= r;
		ren <= !s.is_store;
		wen <= s.is_store;
		// accepting edge
		@(posedge clk);
		ren <= 1'b0;
		wen <= 1'b0;
		n = 0;
		reads = 0;
		writes = 0;
		do begin
			@(posedge clk);
			n++;
			if (mem_ren) begin
				reads++;
			end
			if (mem_wen) begin
				writes++;
			end
		end while (!rdy);
		if (expect_hit) begin
			// hit, rdy is back on the third edge and memory stays idle
			check_value("rdy latency", word_t'(n), word_t'(3));
			check_value("mem_ren count", word_t'(reads), word_t'(0));
			check_value("mem_wen count", word_t'(writes), word_t'(0));
		end else begin
			check_value("mem_ren count", word_t'(reads), word_t'(BLOCK_WORDS));
			check_value("mem_wen count", word_t'(writes),
				word_t'(expect_wb ? BLOCK_WORDS : 0));
		end
		if (s.is_store) begin
			check_value("dout", dout, last_load);
		end else begin
			check_value("dout", dout, s.expected);
			last_load = s.expected;
		end
	endtask

	initial begin
		rst = 1'b1;
		ren = 1'b0;
		wen = 1'b0;
		req = '0;
		for (int s = 0; s < SETS; s++) begin
			model_valid[s] = '0;
			model_dirty[s] = '0;
		end
		model_lru = '0;
		load_stimulus();
		limit = CYCLES_PER_LINE * (stim.size() + 1);
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		foreach (stim[i]) begin
			run_request(stim[i]);
		end
		@(posedge clk);
		$display("%0d errors in %0d requests", errors, stim.size());
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
